//--- include/sat_bkt_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizing of the backtrack stage.
// The bin depth must be a power of two.
// The sweep always covers the full depth of a bin.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SAT_BKT_MACROS_SVH
`define SAT_BKT_MACROS_SVH

// Number of variable banks.
`define BKT_NUM_BINS 4

// Variables held in each bank.
`define BKT_BIN_DEPTH 16

// Address width inside one bank.
`define BKT_ADDR_W ((`BKT_BIN_DEPTH > 1) ? $clog2(`BKT_BIN_DEPTH) : 1)

// Width of a bank index.
`define BKT_BIN_W ((`BKT_NUM_BINS > 1) ? $clog2(`BKT_NUM_BINS) : 1)

// Decision level width.
`define BKT_LVL_W 16

`endif

//--- rtl/sat_bkt_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the backtrack stage.
// An all-zero var state means unassigned.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "sat_bkt_macros.svh"

package sat_bkt_pkg;

    typedef logic [`BKT_LVL_W-1:0]  lvl_t;
    typedef logic [`BKT_ADDR_W-1:0] addr_t;
    typedef logic [`BKT_BIN_W-1:0]  bin_t;

    // 19 bits with the default level width.
    typedef struct packed {
        logic [1:0] asgn;     // Assignment bits.
        logic       implied;  // Set by propagation.
        lvl_t       lvl;      // Decision level.
    } var_state_t;

    typedef struct packed {
        logic start;
        lvl_t lvl;            // Target level.
    } bkt_cmd_t;

    typedef struct packed {
        logic       we;
        logic       re;
        bin_t       bin;
        addr_t      addr;
        var_state_t wdata;
    } host_acc_t;

    // One bank's memory access.
    typedef struct packed {
        logic       we;
        addr_t      waddr;
        var_state_t wdata;
        logic       re;
        addr_t      raddr;
    } bank_port_t;

endpackage

`default_nettype wire

//--- rtl/bkt_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Accepts one backtrack command at a time.
// A start while busy is dropped.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sat_bkt_macros.svh"

module bkt_dispatch (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire sat_bkt_pkg::bkt_cmd_t cmd_i,
    input  wire logic                  all_done_i,
    output logic                       bin_start_o,
    output sat_bkt_pkg::lvl_t          lvl_o,
    output logic                       busy_o
);
    import sat_bkt_pkg::*;

    typedef enum logic {ST_IDLE, ST_BUSY} state_e;

    state_e state_q;
    logic   start_q;
    lvl_t   lvl_q;
    logic   accept;

    assign accept = (state_q == ST_IDLE) && cmd_i.start;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= ST_IDLE;
            start_q <= 1'b0;
        end
        else
        begin
            start_q <= accept;                  // Single-cycle pulse.
            if (accept)
                state_q <= ST_BUSY;
            else if (state_q == ST_BUSY && all_done_i)
                state_q <= ST_IDLE;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            lvl_q <= cmd_i.lvl;                 // Held for the whole sweep.
    end

    assign bin_start_o = start_q;
    assign lvl_o       = lvl_q;
    assign busy_o      = (state_q == ST_BUSY);

    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        cmd_i.start |-> !busy_o)
        else $warning("Backtrack start dropped while busy.");

    a_done_in_busy: assert property (@(posedge clk) disable iff (rst)
        all_done_i |-> busy_o && !bin_start_o);

endmodule

`default_nettype wire

//--- rtl/bkt_across_bin.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sweep engine for one bin.
// Reads every address once, writes back changed states only.
// The target level must stay stable while the engine runs.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sat_bkt_macros.svh"

module bkt_across_bin (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    start_i,
    input  wire sat_bkt_pkg::lvl_t       lvl_i,
    input  wire sat_bkt_pkg::var_state_t rdata_i,
    output sat_bkt_pkg::bank_port_t      port_o,
    output logic                         apply_o,
    output logic                         done_o
);
    import sat_bkt_pkg::*;

    // Covers read latency plus the registered write.
    localparam int unsigned DRAIN_LEN = 3;

    typedef enum logic [1:0] {ST_IDLE, ST_SWEEP, ST_DRAIN, ST_DONE} state_e;

    state_e     state_q;
    addr_t      cnt_q;
    logic [1:0] drain_q;

    logic       rd_vld_q;
    addr_t      rd_addr_q;
    logic       wr_we_q;
    addr_t      wr_addr_q;
    var_state_t wr_data_q;

    var_state_t nxt;
    logic       chg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            drain_q <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (start_i)
                    begin
                        state_q <= ST_SWEEP;
                        cnt_q   <= '0;
                    end
                end
                ST_SWEEP:
                begin
                    if (cnt_q == addr_t'(`BKT_BIN_DEPTH - 1))
                    begin
                        state_q <= ST_DRAIN;
                        drain_q <= '0;
                    end
                    else
                        cnt_q <= cnt_q + 1'b1;
                end
                ST_DRAIN:
                begin
                    if (drain_q == 2'(DRAIN_LEN - 1))
                        state_q <= ST_DONE;
                    else
                        drain_q <= drain_q + 1'b1;
                end
                default:
                    state_q <= ST_IDLE;         // ST_DONE lasts one cycle.
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read and write pipeline
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_vld_q <= 1'b0;
            wr_we_q  <= 1'b0;
        end
        else
        begin
            rd_vld_q <= (state_q == ST_SWEEP);
            wr_we_q  <= rd_vld_q && chg;
        end
    end

    always_ff @(posedge clk)
    begin
        rd_addr_q <= cnt_q;                     // Tracks the returning data.
        wr_addr_q <= rd_addr_q;
        wr_data_q <= nxt;
    end

    // Backtrack rule for one returned state.
    always_comb
    begin
        nxt = rdata_i;
        chg = 1'b0;
        if (rdata_i.lvl == lvl_i && !rdata_i.implied)
        begin
            nxt.asgn    = ~rdata_i.asgn;        // Try the other polarity.
            nxt.implied = 1'b1;
            chg         = 1'b1;
        end
        else if (rdata_i.asgn != 2'b00 && rdata_i.lvl >= lvl_i)
        begin
            nxt = '0;
            chg = 1'b1;
        end
    end

    always_comb
    begin
        port_o.we    = wr_we_q;
        port_o.waddr = wr_addr_q;
        port_o.wdata = wr_data_q;
        port_o.re    = (state_q == ST_SWEEP);
        port_o.raddr = cnt_q;
    end

    assign apply_o = (state_q == ST_SWEEP) || (state_q == ST_DRAIN);
    assign done_o  = (state_q == ST_DONE);

    a_we_in_apply: assert property (@(posedge clk) disable iff (rst)
        port_o.we |-> apply_o);

    a_done_after_sweep: assert property (@(posedge clk) disable iff (rst)
        start_i && state_q == ST_IDLE |->
            !done_o [*(`BKT_BIN_DEPTH + DRAIN_LEN + 1)] ##1 done_o);

endmodule

`default_nettype wire

//--- rtl/var_state_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Variable-state memory of one bin.
// Read data comes one cycle after the read strobe.
// The engine owns the memory while apply is high.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sat_bkt_macros.svh"

module var_state_bank (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire sat_bkt_pkg::host_acc_t  host_i,
    input  wire logic                    sel_i,
    input  wire sat_bkt_pkg::bank_port_t eng_i,
    input  wire logic                    apply_i,
    output sat_bkt_pkg::var_state_t      rdata_o,
    output logic                         rvalid_o
);
    import sat_bkt_pkg::*;

    var_state_t mem [`BKT_BIN_DEPTH];
    var_state_t rdata_q;
    logic       rvalid_q;
    logic       host_act;
    bank_port_t host_port;
    bank_port_t port;

    assign host_act = sel_i && !apply_i;

    always_comb
    begin
        host_port.we    = host_i.we && host_act;
        host_port.waddr = host_i.addr;
        host_port.wdata = host_i.wdata;
        host_port.re    = host_i.re && host_act;
        host_port.raddr = host_i.addr;
    end

    assign port = apply_i ? eng_i : host_port;   // Engine has priority.

    always_ff @(posedge clk)
    begin
        if (port.we)
            mem[port.waddr] <= port.wdata;
        if (port.re)
            rdata_q <= mem[port.raddr];
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            rvalid_q <= 1'b0;
        else
            rvalid_q <= host_port.re;           // Host reads only.
    end

    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;

    a_no_host_wr: assert property (@(posedge clk) disable iff (rst)
        !(host_i.we && sel_i && apply_i));

endmodule

`default_nettype wire

//--- rtl/bkt_done_merge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Joins the done pulses of all bins.
// Each bin may report only once per backtrack.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sat_bkt_macros.svh"

module bkt_done_merge (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [`BKT_NUM_BINS-1:0] bin_done_i,
    output logic                          all_done_o
);

    logic [`BKT_NUM_BINS-1:0] sticky_q;
    logic [`BKT_NUM_BINS-1:0] sticky_nxt;
    logic                     all_q;
    logic                     fire;

    assign sticky_nxt = sticky_q | bin_done_i;
    assign fire       = &sticky_nxt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sticky_q <= '0;
            all_q    <= 1'b0;
        end
        else
        begin
            all_q <= fire;
            if (fire)
                sticky_q <= '0;                 // Ready for the next command.
            else
                sticky_q <= sticky_nxt;
        end
    end

    assign all_done_o = all_q;

    a_single_done: assert property (@(posedge clk) disable iff (rst)
        (bin_done_i & sticky_q) == '0);

endmodule

`default_nettype wire

//--- rtl/bkt_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Backtrack stage with one engine per bin.
// Host accesses are ignored while busy_o is high.
// Commands during busy are dropped.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sat_bkt_macros.svh"

module bkt_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire sat_bkt_pkg::bkt_cmd_t  cmd_i,
    input  wire sat_bkt_pkg::host_acc_t host_i,
    output logic                        busy_o,
    output logic                        done_o,
    output sat_bkt_pkg::var_state_t     rdata_o,
    output logic                        rvalid_o
);
    import sat_bkt_pkg::*;

    logic                     bin_start;
    logic                     all_done;
    lvl_t                     lvl;
    logic [`BKT_NUM_BINS-1:0] bin_done;
    logic [`BKT_NUM_BINS-1:0] apply;
    logic [`BKT_NUM_BINS-1:0] sel;
    logic [`BKT_NUM_BINS-1:0] bank_rvalid;
    bank_port_t               eng_port [`BKT_NUM_BINS];
    var_state_t               bank_rdata [`BKT_NUM_BINS];
    bin_t                     rd_bin_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command dispatch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bkt_dispatch bkt_dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_i       (cmd_i),
        .all_done_i  (all_done),
        .bin_start_o (bin_start),
        .lvl_o       (lvl),
        .busy_o      (busy_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Banks and engines
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < `BKT_NUM_BINS; i++)
    begin : g_bin
        assign sel[i] = (host_i.bin == bin_t'(i)) && !busy_o;

        var_state_bank var_state_bank_i (
            .clk      (clk),
            .rst      (rst),
            .host_i   (host_i),
            .sel_i    (sel[i]),
            .eng_i    (eng_port[i]),
            .apply_i  (apply[i]),
            .rdata_o  (bank_rdata[i]),
            .rvalid_o (bank_rvalid[i])
        );

        bkt_across_bin bkt_across_bin_i (
            .clk     (clk),
            .rst     (rst),
            .start_i (bin_start),
            .lvl_i   (lvl),
            .rdata_i (bank_rdata[i]),
            .port_o  (eng_port[i]),
            .apply_o (apply[i]),
            .done_o  (bin_done[i])
        );
    end

    bkt_done_merge bkt_done_merge_i (
        .clk        (clk),
        .rst        (rst),
        .bin_done_i (bin_done),
        .all_done_o (all_done)
    );

    // Bank index of the pending host read.
    always_ff @(posedge clk)
    begin
        if (host_i.re && !busy_o)
            rd_bin_q <= host_i.bin;
    end

    assign rdata_o  = bank_rdata[rd_bin_q];
    assign rvalid_o = |bank_rvalid;
    assign done_o   = all_done;

endmodule

`default_nettype wire

//--- dv/bkt_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Self-checking testbench for the backtrack stage.
// Host reads are issued only while busy_o is low.
// Outputs are sampled on the falling clock edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "sat_bkt_macros.svh"

module bkt_tb;
    import sat_bkt_pkg::*;

    localparam int DEPTH    = `BKT_BIN_DEPTH;
    localparam int TOTAL    = `BKT_NUM_BINS * `BKT_BIN_DEPTH;
    localparam int DONE_LAT = DEPTH + 6;
    localparam int NUM_CMDS = 6;                // Accepted and dropped starts.
    localparam int NUM_XFER = 9;                // Three loads, six readbacks.
    localparam int TIMEOUT  = NUM_CMDS * (DEPTH + 10) + NUM_XFER * (TOTAL + 4) + 20;

    logic       clk;
    logic       rst;
    bkt_cmd_t   cmd_i;
    host_acc_t  host_i;
    logic       busy_o;
    logic       done_o;
    var_state_t rdata_o;
    logic       rvalid_o;

    var_state_t  shadow [TOTAL];                // Model of all bins.
    var_state_t  exp_val_q [$];
    int          exp_idx_q [$];
    logic [31:0] rng_state = 32'h3f273fb5;
    int          cycle_cnt = 0;
    logic        re_prev   = 1'b0;

    bkt_top bkt_top_i (
        .clk      (clk),
        .rst      (rst),
        .cmd_i    (cmd_i),
        .host_i   (host_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .rdata_o  (rdata_o),
        .rvalid_o (rvalid_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped on first error.");
    endtask

    function automatic logic [31:0] rand_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Expected state of one variable after a backtrack to lvl.
    function automatic var_state_t backtrack_ref(input var_state_t s, input lvl_t lvl);
        var_state_t r;
        r = s;
        if (s.lvl == lvl && s.implied == 1'b0)
        begin
            r.asgn    = ~s.asgn;
            r.implied = 1'b1;
        end
        else if (s.asgn != 2'b00 && s.lvl >= lvl)
            r = '0;
        return r;
    endfunction

    function automatic var_state_t random_state(input logic [31:0] r);
        var_state_t s;
        s.asgn    = r[1:0];
        s.implied = r[2];
        s.lvl     = lvl_t'(r[5:3]);             // Levels 0 to 7.
        if (s.asgn == 2'b00)
            s = '0;                             // Unassigned is all zero.
        return s;
    endfunction

    // One rule class per index, cycling through all cases.
    function automatic var_state_t shaped_state(input int idx, input lvl_t lvl,
                                                input logic [31:0] r);
        var_state_t s;
        s.asgn    = r[0] ? 2'b01 : 2'b10;
        s.implied = 1'b0;
        s.lvl     = lvl;
        case (idx % 5)
            0: s.implied = 1'b0;                // Decision at target.
            1: s.implied = 1'b1;                // Implied at target.
            2:
            begin
                s.implied = r[3];
                s.lvl     = lvl_t'(lvl + 1 + r[5:4]);
            end
            3:
            begin
                s.implied = r[3];
                s.lvl     = lvl_t'(lvl - 1 - r[4]);
            end
            default: s = '0;
        endcase
        return s;
    endfunction

    task automatic load_all(input bit shaped, input lvl_t lvl);
        var_state_t s;
        for (int i = 0; i < TOTAL; i++)
        begin
            s = shaped ? shaped_state(i, lvl, rand_word()) : random_state(rand_word());
            shadow[i] = s;
            @(posedge clk);
            host_i <= '{we: 1'b1, re: 1'b0, bin: bin_t'(i / DEPTH),
                        addr: addr_t'(i % DEPTH), wdata: s};
        end
        @(posedge clk);
        host_i <= '0;
    endtask

    task automatic read_all();
        for (int i = 0; i < TOTAL; i++)
        begin
            @(posedge clk);
            host_i <= '{we: 1'b0, re: 1'b1, bin: bin_t'(i / DEPTH),
                        addr: addr_t'(i % DEPTH), wdata: '0};
            exp_val_q.push_back(shadow[i]);
            exp_idx_q.push_back(i);
        end
        @(posedge clk);
        host_i <= '0;
        while (exp_val_q.size() != 0)
            @(negedge clk);
    endtask

    // Issues one start; optionally a second start while busy.
    task automatic run_backtrack(input lvl_t lvl, input bit extra);
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        @(posedge clk);
        cmd_i <= '{start: 1'b1, lvl: lvl};
        while (!seen)
        begin
            @(negedge clk);
            assert (busy_o == (n >= 1)) else
                abort_run($sformatf("Mismatch at %0t: busy_o got %b expected %b",
                                    $time, busy_o, n >= 1));
            if (done_o)
            begin
                assert (n == DONE_LAT) else
                    abort_run($sformatf("Mismatch at %0t: done_o cycle got %0d expected %0d",
                                        $time, n, DONE_LAT));
                seen = 1'b1;
            end
            else
            begin
                assert (n < DONE_LAT) else
                    abort_run("done_o did not pulse after an accepted start.");
            end
            @(posedge clk);
            if (extra && n == 4)
                cmd_i <= '{start: 1'b1, lvl: lvl_t'(lvl + 3)};
            else
                cmd_i <= '{start: 1'b0, lvl: lvl};
            n++;
        end
        @(negedge clk);
        assert (!busy_o && !done_o) else
            abort_run($sformatf("Mismatch at %0t: busy_o/done_o got %b/%b expected 0/0",
                                $time, busy_o, done_o));
        for (int i = 0; i < TOTAL; i++)
            shadow[i] = backtrack_ref(shadow[i], lvl);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk)
    begin
        var_state_t exp;
        int idx;
        if (!rst)
        begin
            assert (rvalid_o == re_prev) else
                abort_run($sformatf("Mismatch at %0t: rvalid_o got %b expected %b",
                                    $time, rvalid_o, re_prev));
            if (rvalid_o)
            begin
                assert (exp_val_q.size() != 0) else
                    abort_run("rvalid_o rose with no host read pending.");
                exp = exp_val_q.pop_front();
                idx = exp_idx_q.pop_front();
                assert (rdata_o == exp) else
                    abort_run($sformatf(
                        "Mismatch at %0t: rdata_o bin %0d addr %0d got %h expected %h",
                        $time, idx / DEPTH, idx % DEPTH, rdata_o, exp));
            end
        end
        re_prev = host_i.re;                    // Response due next cycle.
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT)
            abort_run($sformatf("Timeout after %0d cycles, the run did not finish.", cycle_cnt));
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        lvl_t lvl_cur;
        rst    = 1'b1;
        cmd_i  = '0;
        host_i = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        load_all(1'b0, '0);                     // Random load and readback.
        read_all();

        load_all(1'b1, lvl_t'(5));              // All rule classes at level 5.
        run_backtrack(lvl_t'(5), 1'b1);
        read_all();

        load_all(1'b0, '0);
        lvl_cur = lvl_t'(9);
        for (int k = 0; k < 4; k++)
        begin
            lvl_cur = lvl_t'(lvl_cur - 1 - (rand_word() & 32'h1));
            run_backtrack(lvl_cur, 1'b0);
            read_all();
        end

        repeat (2) @(negedge clk);
        if (exp_val_q.size() == 0)
        begin
            $display("RESULT: PASS");
            $finish;
        end
        else
            abort_run("Host reads were left without a response.");
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
rtl/sat_bkt_pkg.sv
rtl/bkt_dispatch.sv
rtl/bkt_across_bin.sv
rtl/var_state_bank.sv
rtl/bkt_done_merge.sv
rtl/bkt_top.sv
dv/bkt_tb.sv

//--- Bender.yml
package:
  name: sat_bkt

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/sat_bkt_pkg.sv
      - rtl/bkt_dispatch.sv
      - rtl/bkt_across_bin.sv
      - rtl/var_state_bank.sv
      - rtl/bkt_done_merge.sv
      - rtl/bkt_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/bkt_tb.sv
